// ==== list.f ====
verilog/ex_isa_pkg.sv
verilog/ex_rf_pkg.sv
verilog/ex_alu.sv
verilog/mul_issue.sv
verilog/mul_stage.sv
verilog/mul_retire.sv
verilog/ex_stage.sv
verif/ex_stage_props.sv
verif/ex_stage_tb.sv

// ==== verif/ex_stage_props.sv ====
module ex_stage_props
  import ex_isa_pkg::*;
  import ex_rf_pkg::*;
#(
  parameter int MUL_STAGES = 4
) (
  input logic     clk,
  input logic     rst_n,
  input logic     alu_en_i,
  input alu_op_e  alu_op_i,
  input word_t    alu_operand_a_i,
  input word_t    alu_operand_b_i,
  input rf_addr_t alu_waddr_i,
  input logic     mul_en_i,
  input mul_op_e  mul_op_i,
  input word_t    mul_operand_a_i,
  input word_t    mul_operand_b_i,
  input rf_addr_t mul_waddr_i,
  input logic     alu_we_o,
  input rf_addr_t alu_waddr_o,
  input word_t    alu_wdata_o,
  input logic     branch_decision_o,
  input logic     mul_we_o,
  input rf_addr_t mul_waddr_o,
  input word_t    mul_wdata_o,
  input logic     mul_busy_o
);

  // Strobe to write port: issue register, the stages, retire register
  localparam int LAT = MUL_STAGES + 2;

  // Count of failed checks, watched by the testbench
  int       err_count = 0;

  logic     alu_en_q;
  alu_op_e  alu_op_q;
  word_t    alu_a_q;
  word_t    alu_b_q;
  rf_addr_t alu_waddr_q;
  word_t    alu_exp;
  logic     cmp_exp;

  logic [LAT:1] mul_en_h;
  mul_op_e      mul_op_h    [1:LAT];
  word_t        mul_a_h     [1:LAT];
  word_t        mul_b_h     [1:LAT];
  rf_addr_t     mul_waddr_h [1:LAT];
  word_t        mul_exp;
  logic         busy_exp;

  ////////////////////
  // Reference rules
  ////////////////////
  function automatic logic is_cmp(input alu_op_e op);
    return (op >= ALU_EQ);
  endfunction

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    int unsigned sh;
    sh = b[SHAMT_W-1:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      // Sign copies above the word shift in from the top
      ALU_SRA: return word_t'({{XLEN{a[XLEN-1]}}, a} >> sh);
      ALU_EQ:  return word_t'(a == b);
      ALU_NE:  return word_t'(a != b);
      ALU_LT:  return word_t'($signed(a) < $signed(b));
      ALU_LTU: return word_t'(a < b);
      ALU_GE:  return word_t'($signed(a) >= $signed(b));
      ALU_GEU: return word_t'(a >= b);
      default: return '0;
    endcase
  endfunction

  // True 64-bit products, signed and unsigned
  function automatic word_t mul_model(input mul_op_e op, input word_t a, input word_t b);
    dword_t prod_s;
    dword_t prod_u;
    prod_s = dword_t'($signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b}));
    prod_u = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      MUL_H:   return prod_s[2*XLEN-1:XLEN];
      MUL_HU:  return prod_u[2*XLEN-1:XLEN];
      default: return prod_u[XLEN-1:0];
    endcase
  endfunction

  // ALU inputs seen one edge ago
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_en_q <= 1'b0;
      mul_en_h <= '0;
    end else begin
      alu_en_q <= alu_en_i;
      mul_en_h <= {mul_en_h[LAT-1:1], mul_en_i};
    end
  end

  // Operand history, index k holds the inputs of k edges ago
  always_ff @(posedge clk) begin
    alu_op_q       <= alu_op_i;
    alu_a_q        <= alu_operand_a_i;
    alu_b_q        <= alu_operand_b_i;
    alu_waddr_q    <= alu_waddr_i;
    mul_op_h[1]    <= mul_op_i;
    mul_a_h[1]     <= mul_operand_a_i;
    mul_b_h[1]     <= mul_operand_b_i;
    mul_waddr_h[1] <= mul_waddr_i;
    for (int k = 2; k <= LAT; k++) begin
      mul_op_h[k]    <= mul_op_h[k-1];
      mul_a_h[k]     <= mul_a_h[k-1];
      mul_b_h[k]     <= mul_b_h[k-1];
      mul_waddr_h[k] <= mul_waddr_h[k-1];
    end
  end

  assign alu_exp  = alu_model(alu_op_q, alu_a_q, alu_b_q);
  assign cmp_exp  = alu_en_q && is_cmp(alu_op_q) && alu_exp[0];
  assign mul_exp  = mul_model(mul_op_h[LAT], mul_a_h[LAT], mul_b_h[LAT]);
  // In flight from the issue register up to the last stage
  assign busy_exp = |mul_en_h[LAT-1:1];

  ////////////////////
  // Checks
  ////////////////////
  // First edge after reset release
  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> !alu_we_o && !mul_we_o && !branch_decision_o && !mul_busy_o)
    else begin
      $error("write enable, branch or busy output is active after reset");
      err_count = err_count + 1;
    end

  a_alu_we: assert property (@(posedge clk) disable iff (!rst_n) alu_we_o == alu_en_q)
    else begin
      $error("error alu_we_o exp %h got %h", $sampled(alu_en_q), $sampled(alu_we_o));
      err_count = err_count + 1;
    end

  a_alu_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    alu_en_q |-> alu_waddr_o == alu_waddr_q)
    else begin
      $error("error alu_waddr_o exp %h got %h", $sampled(alu_waddr_q), $sampled(alu_waddr_o));
      err_count = err_count + 1;
    end

  a_alu_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    alu_en_q |-> alu_wdata_o == alu_exp)
    else begin
      $error("error alu_wdata_o exp %h got %h", $sampled(alu_exp), $sampled(alu_wdata_o));
      err_count = err_count + 1;
    end

  // Low outside the write cycle and for non-comparisons
  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_decision_o == cmp_exp)
    else begin
      $error("error branch_decision_o exp %h got %h", $sampled(cmp_exp),
             $sampled(branch_decision_o));
      err_count = err_count + 1;
    end

  a_mul_we: assert property (@(posedge clk) disable iff (!rst_n) mul_we_o == mul_en_h[LAT])
    else begin
      $error("error mul_we_o exp %h got %h", $sampled(mul_en_h[LAT]), $sampled(mul_we_o));
      err_count = err_count + 1;
    end

  a_mul_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    mul_en_h[LAT] |-> mul_waddr_o == mul_waddr_h[LAT])
    else begin
      $error("error mul_waddr_o exp %h got %h", $sampled(mul_waddr_h[LAT]),
             $sampled(mul_waddr_o));
      err_count = err_count + 1;
    end

  a_mul_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    mul_en_h[LAT] |-> mul_wdata_o == mul_exp)
    else begin
      $error("error mul_wdata_o exp %h got %h", $sampled(mul_exp), $sampled(mul_wdata_o));
      err_count = err_count + 1;
    end

  a_mul_busy: assert property (@(posedge clk) disable iff (!rst_n) mul_busy_o == busy_exp)
    else begin
      $error("error mul_busy_o exp %h got %h", $sampled(busy_exp), $sampled(mul_busy_o));
      err_count = err_count + 1;
    end

endmodule

bind ex_stage ex_stage_props #(.MUL_STAGES(MUL_STAGES)) i_props (.*);

// ==== verif/ex_stage_tb.sv ====
module ex_stage_tb
  import ex_isa_pkg::*;
  import ex_rf_pkg::*;
();

  localparam int MUL_STAGES = 4;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;
  // Issue slots, corner sweep first, then random
  localparam int N_OPS      = 400;
  localparam int N_CORNER   = 48;
  localparam int RUN_CYCLES = RST_CYCLES + N_OPS + MUL_STAGES + 10;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] lfsr;

  logic     alu_en_i;
  alu_op_e  alu_op_i;
  word_t    alu_operand_a_i;
  word_t    alu_operand_b_i;
  rf_addr_t alu_waddr_i;
  logic     mul_en_i;
  mul_op_e  mul_op_i;
  word_t    mul_operand_a_i;
  word_t    mul_operand_b_i;
  rf_addr_t mul_waddr_i;

  logic     alu_we_o;
  rf_addr_t alu_waddr_o;
  word_t    alu_wdata_o;
  logic     branch_decision_o;
  logic     mul_we_o;
  rf_addr_t mul_waddr_o;
  word_t    mul_wdata_o;
  logic     mul_busy_o;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ex_stage #(
    .MUL_STAGES (MUL_STAGES)
  ) i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_en_i          (alu_en_i),
    .alu_op_i          (alu_op_i),
    .alu_operand_a_i   (alu_operand_a_i),
    .alu_operand_b_i   (alu_operand_b_i),
    .alu_waddr_i       (alu_waddr_i),
    .mul_en_i          (mul_en_i),
    .mul_op_i          (mul_op_i),
    .mul_operand_a_i   (mul_operand_a_i),
    .mul_operand_b_i   (mul_operand_b_i),
    .mul_waddr_i       (mul_waddr_i),
    .alu_we_o          (alu_we_o),
    .alu_waddr_o       (alu_waddr_o),
    .alu_wdata_o       (alu_wdata_o),
    .branch_decision_o (branch_decision_o),
    .mul_we_o          (mul_we_o),
    .mul_waddr_o       (mul_waddr_o),
    .mul_wdata_o       (mul_wdata_o),
    .mul_busy_o        (mul_busy_o)
  );

  ////////////////////
  // Random source
  ////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic word_t corner_word(input logic [1:0] sel);
    case (sel)
      2'd0:    return 32'h0000_0000;
      2'd1:    return 32'h0000_0001;
      2'd2:    return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // One word in four is a corner
  function automatic word_t pick_word();
    if (take_bits(2) == 0) begin
      return corner_word(2'(take_bits(2)));
    end
    return take_bits(32);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  // Stop at the first failed check
  initial begin
    wait (i_dut.i_props.err_count != 0);
    abort_run("a check on the DUT outputs failed");
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    abort_run("timeout, the run did not finish in time");
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    lfsr            = 32'he012_f97c;
    rst_n           = 1'b0;
    alu_en_i        = 1'b0;
    alu_op_i        = ALU_ADD;
    alu_operand_a_i = '0;
    alu_operand_b_i = '0;
    alu_waddr_i     = '0;
    mul_en_i        = 1'b0;
    mul_op_i        = MUL_L;
    mul_operand_a_i = '0;
    mul_operand_b_i = '0;
    mul_waddr_i     = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet cycles, outputs must stay low
    repeat (2) next_cycle();

    // Every corner pair under each multiply, back to back
    for (int i = 0; i < N_CORNER; i++) begin
      alu_en_i        = 1'b1;
      alu_op_i        = alu_op_e'(i % 14);
      alu_operand_a_i = corner_word(i[3:2]);
      alu_operand_b_i = corner_word(i[1:0]);
      alu_waddr_i     = rf_addr_t'(i);
      mul_en_i        = 1'b1;
      mul_op_i        = mul_op_e'(i / 16);
      mul_operand_a_i = corner_word(i[3:2]);
      mul_operand_b_i = corner_word(i[1:0]);
      mul_waddr_i     = rf_addr_t'(63 - i);
      next_cycle();
    end

    // Mostly busy ALU, multiplier half the time so busy can drop
    for (int i = N_CORNER; i < N_OPS; i++) begin
      alu_en_i        = (take_bits(3) != 0);
      alu_op_i        = alu_op_e'(take_bits(4) % 14);
      alu_operand_a_i = pick_word();
      alu_operand_b_i = pick_word();
      alu_waddr_i     = rf_addr_t'(take_bits(RF_ADDR_W));
      mul_en_i        = (take_bits(1) != 0);
      mul_op_i        = mul_op_e'(take_bits(2) % 3);
      mul_operand_a_i = pick_word();
      mul_operand_b_i = pick_word();
      mul_waddr_i     = rf_addr_t'(take_bits(RF_ADDR_W));
      next_cycle();
    end
    alu_en_i = 1'b0;
    mul_en_i = 1'b0;

    // Drain the multiplier
    do begin
      next_cycle();
    end while (mul_busy_o || mul_we_o);
    @(posedge clk);

    if (i_dut.i_props.err_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("failed checks were counted during the run");
    end
  end

endmodule

// ==== verilog/ex_alu.sv ====
module ex_alu
  import ex_isa_pkg::*;
  import ex_rf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Issue strobe and operands
  input  logic     en_i,
  input  alu_op_e  op_i,
  input  word_t    operand_a_i,
  input  word_t    operand_b_i,
  input  rf_addr_t waddr_i,

  // Registered write port
  output logic     we_o,
  output rf_addr_t waddr_o,
  output word_t    wdata_o,
  output logic     cmp_o
);

  logic                 is_sub;
  word_t                adder_b;
  logic [XLEN:0]        adder_res;
  logic                 is_eq;
  logic                 lt_s;
  logic                 lt_u;
  logic [SHAMT_W-1:0]   shamt;
  logic                 cmp_res;
  word_t                result;

  logic                 we_q;
  rf_addr_t             waddr_q;
  word_t                wdata_q;
  logic                 cmp_q;

  ////////////////////
  // Adder
  ////////////////////
  // Everything but ADD subtracts, comparisons reuse the difference
  assign is_sub    = (op_i != ALU_ADD);
  assign adder_b   = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_res = {1'b0, operand_a_i} + {1'b0, adder_b} + {{XLEN{1'b0}}, is_sub};

  // Carry out of a - b is set when a >= b unsigned
  assign lt_u  = ~adder_res[XLEN];
  // Differing signs decide directly, otherwise the sign of the difference
  assign lt_s  = (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) ? operand_a_i[XLEN-1]
                                                             : adder_res[XLEN-1];
  assign is_eq = (operand_a_i == operand_b_i);

  // Only the low bits of b count for shifts
  assign shamt = operand_b_i[SHAMT_W-1:0];

  ////////////////////
  // Branch comparison
  ////////////////////
  always_comb begin
    case (op_i)
      ALU_EQ:  cmp_res = is_eq;
      ALU_NE:  cmp_res = ~is_eq;
      ALU_LT:  cmp_res = lt_s;
      ALU_LTU: cmp_res = lt_u;
      ALU_GE:  cmp_res = ~lt_s;
      ALU_GEU: cmp_res = ~lt_u;
      // Not a comparison
      default: cmp_res = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (op_i)
      ALU_ADD, ALU_SUB: result = adder_res[XLEN-1:0];
      ALU_AND:          result = operand_a_i & operand_b_i;
      ALU_OR:           result = operand_a_i | operand_b_i;
      ALU_XOR:          result = operand_a_i ^ operand_b_i;
      ALU_SLL:          result = operand_a_i << shamt;
      ALU_SRL:          result = operand_a_i >> shamt;
      ALU_SRA:          result = word_t'($signed(operand_a_i) >>> shamt);
      // Comparisons write 1 or 0
      default:          result = {{(XLEN-1){1'b0}}, cmp_res};
    endcase
  end

  ////////////////////
  // Output register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      cmp_q   <= 1'b0;
      waddr_q <= '0;
      wdata_q <= '0;
    end else begin
      we_q  <= en_i;
      // Decision only shows in the write cycle
      cmp_q <= en_i & cmp_res;
      if (en_i) begin
        waddr_q <= waddr_i;
        wdata_q <= result;
      end
    end
  end

  assign we_o    = we_q;
  assign waddr_o = waddr_q;
  assign wdata_o = wdata_q;
  assign cmp_o   = cmp_q;

endmodule

// ==== verilog/ex_isa_pkg.sv ====
package ex_isa_pkg;

  // Data path width
  localparam int XLEN    = 32;
  // Shift amount taken from the low bits of operand b
  localparam int SHAMT_W = 5;

  typedef logic [XLEN-1:0]   word_t;
  // Full product of two words
  typedef logic [2*XLEN-1:0] dword_t;

  ////////////////////
  // ALU operations
  ////////////////////
  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SLL = 4'h5,
    ALU_SRL = 4'h6,
    ALU_SRA = 4'h7,
    // Comparisons, result is a single bit
    ALU_EQ  = 4'h8,
    ALU_NE  = 4'h9,
    ALU_LT  = 4'ha,
    ALU_LTU = 4'hb,
    ALU_GE  = 4'hc,
    ALU_GEU = 4'hd
  } alu_op_e;

  ////////////////////
  // Multiply operations
  ////////////////////
  typedef enum logic [1:0] {
    MUL_L  = 2'b00,  // low word
    MUL_H  = 2'b01,  // high word, signed x signed
    MUL_HU = 2'b10   // high word, unsigned x unsigned
  } mul_op_e;

endpackage

// ==== verilog/ex_rf_pkg.sv ====
package ex_rf_pkg;

  // Register file address width
  // Six bits leave room for a second register bank
  localparam int RF_ADDR_W = 6;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

endpackage

// ==== verilog/ex_stage.sv ====
module ex_stage
  import ex_isa_pkg::*;
  import ex_rf_pkg::*;
#(
  // Pipeline depth of the multiplier, one of 1, 2, 4, 8
  parameter int MUL_STAGES = 4
) (
  input  logic     clk,
  input  logic     rst_n,

  // ALU issue
  input  logic     alu_en_i,
  input  alu_op_e  alu_op_i,
  input  word_t    alu_operand_a_i,
  input  word_t    alu_operand_b_i,
  input  rf_addr_t alu_waddr_i,

  // Multiplier issue
  input  logic     mul_en_i,
  input  mul_op_e  mul_op_i,
  input  word_t    mul_operand_a_i,
  input  word_t    mul_operand_b_i,
  input  rf_addr_t mul_waddr_i,

  // ALU write port and branch decision
  output logic     alu_we_o,
  output rf_addr_t alu_waddr_o,
  output word_t    alu_wdata_o,
  output logic     branch_decision_o,

  // Multiplier write port
  output logic     mul_we_o,
  output rf_addr_t mul_waddr_o,
  output word_t    mul_wdata_o,
  output logic     mul_busy_o
);

  // Chain index 0 is the issue register, index i+1 is stage i
  logic [MUL_STAGES:0] pipe_valid;
  dword_t              pipe_mcand  [MUL_STAGES+1];
  word_t               pipe_mplier [MUL_STAGES+1];
  dword_t              pipe_acc    [MUL_STAGES+1];
  logic                pipe_neg    [MUL_STAGES+1];
  mul_op_e             pipe_op     [MUL_STAGES+1];
  rf_addr_t            pipe_waddr  [MUL_STAGES+1];

  ////////////////////
  // ALU
  ////////////////////
  ex_alu i_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .en_i        (alu_en_i),
    .op_i        (alu_op_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .waddr_i     (alu_waddr_i),
    .we_o        (alu_we_o),
    .waddr_o     (alu_waddr_o),
    .wdata_o     (alu_wdata_o),
    .cmp_o       (branch_decision_o)
  );

  ////////////////////
  // Multiplier
  ////////////////////
  mul_issue i_mul_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .en_i        (mul_en_i),
    .op_i        (mul_op_i),
    .operand_a_i (mul_operand_a_i),
    .operand_b_i (mul_operand_b_i),
    .waddr_i     (mul_waddr_i),
    .valid_o     (pipe_valid[0]),
    .mcand_o     (pipe_mcand[0]),
    .mplier_o    (pipe_mplier[0]),
    .acc_o       (pipe_acc[0]),
    .neg_o       (pipe_neg[0]),
    .op_o        (pipe_op[0]),
    .waddr_o     (pipe_waddr[0])
  );

  // One shift-add stage per slice of the multiplier
  for (genvar i = 0; i < MUL_STAGES; i++) begin : g_mul_stage
    mul_stage #(
      .MUL_STAGES (MUL_STAGES),
      .STAGE_IDX  (i)
    ) i_mul_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .valid_i  (pipe_valid[i]),
      .mcand_i  (pipe_mcand[i]),
      .mplier_i (pipe_mplier[i]),
      .acc_i    (pipe_acc[i]),
      .neg_i    (pipe_neg[i]),
      .op_i     (pipe_op[i]),
      .waddr_i  (pipe_waddr[i]),
      .valid_o  (pipe_valid[i+1]),
      .mcand_o  (pipe_mcand[i+1]),
      .mplier_o (pipe_mplier[i+1]),
      .acc_o    (pipe_acc[i+1]),
      .neg_o    (pipe_neg[i+1]),
      .op_o     (pipe_op[i+1]),
      .waddr_o  (pipe_waddr[i+1])
    );
  end

  mul_retire i_mul_retire (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (pipe_valid[MUL_STAGES]),
    .acc_i   (pipe_acc[MUL_STAGES]),
    .neg_i   (pipe_neg[MUL_STAGES]),
    .op_i    (pipe_op[MUL_STAGES]),
    .waddr_i (pipe_waddr[MUL_STAGES]),
    .we_o    (mul_we_o),
    .waddr_o (mul_waddr_o),
    .wdata_o (mul_wdata_o)
  );

  // Busy while the issue register or any stage holds an item
  assign mul_busy_o = |pipe_valid;

endmodule

// ==== verilog/mul_issue.sv ====
module mul_issue
  import ex_isa_pkg::*;
  import ex_rf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Issue strobe and operands
  input  logic     en_i,
  input  mul_op_e  op_i,
  input  word_t    operand_a_i,
  input  word_t    operand_b_i,
  input  rf_addr_t waddr_i,

  // Item for stage 0
  output logic     valid_o,
  output dword_t   mcand_o,
  output word_t    mplier_o,
  output dword_t   acc_o,
  output logic     neg_o,
  output mul_op_e  op_o,
  output rf_addr_t waddr_o
);

  logic     a_neg;
  logic     b_neg;
  word_t    a_mag;
  word_t    b_mag;

  logic     valid_q;
  dword_t   mcand_q;
  word_t    mplier_q;
  logic     neg_q;
  mul_op_e  op_q;
  rf_addr_t waddr_q;

  // Operands are signed only for MUL_H
  assign a_neg = (op_i == MUL_H) && operand_a_i[XLEN-1];
  assign b_neg = (op_i == MUL_H) && operand_b_i[XLEN-1];

  // Magnitudes, 32'h8000_0000 stays correct as unsigned
  assign a_mag = a_neg ? (~operand_a_i + 1'b1) : operand_a_i;
  assign b_mag = b_neg ? (~operand_b_i + 1'b1) : operand_b_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= 1'b0;
      mcand_q  <= '0;
      mplier_q <= '0;
      neg_q    <= 1'b0;
      op_q     <= MUL_L;
      waddr_q  <= '0;
    end else begin
      valid_q <= en_i;
      if (en_i) begin
        // Multiplicand widened so stages can shift it left
        mcand_q  <= {{XLEN{1'b0}}, a_mag};
        mplier_q <= b_mag;
        neg_q    <= a_neg ^ b_neg;
        op_q     <= op_i;
        waddr_q  <= waddr_i;
      end
    end
  end

  assign valid_o  = valid_q;
  assign mcand_o  = mcand_q;
  assign mplier_o = mplier_q;
  // Accumulation starts at zero
  assign acc_o    = '0;
  assign neg_o    = neg_q;
  assign op_o     = op_q;
  assign waddr_o  = waddr_q;

endmodule

// ==== verilog/mul_retire.sv ====
module mul_retire
  import ex_isa_pkg::*;
  import ex_rf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Item from the last stage
  input  logic     valid_i,
  input  dword_t   acc_i,
  input  logic     neg_i,
  input  mul_op_e  op_i,
  input  rf_addr_t waddr_i,

  // Multiplier write port
  output logic     we_o,
  output rf_addr_t waddr_o,
  output word_t    wdata_o
);

  dword_t   product;
  word_t    result;

  logic     we_q;
  rf_addr_t waddr_q;
  word_t    wdata_q;

  // Restore the sign of a MUL_H product
  assign product = neg_i ? (~acc_i + 1'b1) : acc_i;

  // Half select
  always_comb begin
    if (op_i == MUL_L) begin
      result = product[XLEN-1:0];
    end else begin
      // MUL_H and MUL_HU
      result = product[2*XLEN-1:XLEN];
    end
  end

  ////////////////////
  // Write port register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
      wdata_q <= '0;
    end else begin
      we_q <= valid_i;
      if (valid_i) begin
        waddr_q <= waddr_i;
        wdata_q <= result;
      end
    end
  end

  assign we_o    = we_q;
  assign waddr_o = waddr_q;
  assign wdata_o = wdata_q;

endmodule

// ==== verilog/mul_stage.sv ====
module mul_stage
  import ex_isa_pkg::*;
  import ex_rf_pkg::*;
#(
  parameter int MUL_STAGES = 4,
  parameter int STAGE_IDX  = 0
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     valid_i,
  input  dword_t   mcand_i,
  input  word_t    mplier_i,
  input  dword_t   acc_i,
  input  logic     neg_i,
  input  mul_op_e  op_i,
  input  rf_addr_t waddr_i,

  output logic     valid_o,
  output dword_t   mcand_o,
  output word_t    mplier_o,
  output dword_t   acc_o,
  output logic     neg_o,
  output mul_op_e  op_o,
  output rf_addr_t waddr_o
);

  // Multiplier bits handled here
  localparam int SLICE_W  = XLEN / MUL_STAGES;
  localparam int SLICE_LO = STAGE_IDX * SLICE_W;

  logic [SLICE_W-1:0] slice;
  dword_t             acc_sum;

  assign slice = mplier_i[SLICE_LO +: SLICE_W];

  // Shift-add over the slice
  // mcand_i already carries the shift of earlier stages
  always_comb begin
    acc_sum = acc_i;
    for (int j = 0; j < SLICE_W; j++) begin
      if (slice[j]) begin
        acc_sum = acc_sum + (mcand_i << j);
      end
    end
  end

  ////////////////////
  // Stage register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o  <= 1'b0;
      mcand_o  <= '0;
      mplier_o <= '0;
      acc_o    <= '0;
      neg_o    <= 1'b0;
      op_o     <= MUL_L;
      waddr_o  <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        // Line the multiplicand up with the next slice
        mcand_o  <= mcand_i << SLICE_W;
        mplier_o <= mplier_i;
        acc_o    <= acc_sum;
        neg_o    <= neg_i;
        op_o     <= op_i;
        waddr_o  <= waddr_i;
      end
    end
  end

endmodule
